//--- src/lsu_pkg.sv
// lsu shared constants, access-size enum and size_bytes helper
package lsu_pkg;

  localparam int XLEN   = 64;             // data and address width
  localparam int STRB_W = XLEN / 8;       // bytes per lane
  localparam int OFF_W  = $clog2(STRB_W); // byte offset bits of an address

  // access size, encoded as log2 of the byte count
  typedef enum logic [1:0] {
    SIZE_B = 2'd0,
    SIZE_H = 2'd1,
    SIZE_W = 2'd2,
    SIZE_D = 2'd3
  } mem_size_e;

  // bytes moved by one access
  function automatic logic [3:0] size_bytes(input mem_size_e size);
    logic [3:0] n;
    case (size)
      SIZE_B:  n = 4'd1;
      SIZE_H:  n = 4'd2;
      SIZE_W:  n = 4'd4;
      default: n = 4'd8;
    endcase
    return n;
  endfunction

endpackage

//--- src/dmem_bus_if.sv
// data memory bus interface with write, write response, read and read data channels
`timescale 1ns/1ps

interface dmem_bus_if;

  import lsu_pkg::*;

  // write request, address and lane travel together
  logic              aw_valid;
  logic              aw_ready;
  logic [XLEN-1:0]   aw_addr;
  logic [XLEN-1:0]   w_data;
  logic [STRB_W-1:0] w_strb;    // one bit per byte lane

  logic              b_valid;   // write response
  logic              b_ready;

  logic              ar_valid;  // read request
  logic              ar_ready;
  logic [XLEN-1:0]   ar_addr;

  logic              r_valid;   // read data
  logic              r_ready;
  logic [XLEN-1:0]   r_data;    // full lane, unshifted

  modport master (
    output aw_valid, aw_addr, w_data, w_strb, b_ready,
    output ar_valid, ar_addr, r_ready,
    input  aw_ready, b_valid, ar_ready, r_valid, r_data
  );

  modport slave (
    input  aw_valid, aw_addr, w_data, w_strb, b_ready,
    input  ar_valid, ar_addr, r_ready,
    output aw_ready, b_valid, ar_ready, r_valid, r_data
  );

endinterface

//--- src/load_store_unit.sv
// load/store unit: store lane alignment, load shift and extension, bus handshake FSM
`timescale 1ns/1ps

module load_store_unit (
  input  logic                     clk,
  input  logic                     arst_n_i,
  input  logic                     load_i,
  input  logic                     store_i,
  input  logic [lsu_pkg::XLEN-1:0] addr_i,
  input  logic [lsu_pkg::XLEN-1:0] wdata_i,
  input  lsu_pkg::mem_size_e       size_i,
  input  logic                     sext_i,
  output logic [lsu_pkg::XLEN-1:0] rdata_o,
  output logic                     done_o,
  output logic                     busy_o,
  dmem_bus_if.master               bus
);

  import lsu_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    REQ,
    RESP
  } state_e;

  state_e            state_q;
  logic              accept;
  logic [OFF_W-1:0]  off;
  logic [STRB_W:0]   mask_wide;
  logic [STRB_W-1:0] lane_mask;
  logic [XLEN-1:0]   lane_data;

  mem_size_e         size_q;    // load attributes kept until the data returns
  logic              sext_q;
  logic [OFF_W-1:0]  off_q;
  logic [XLEN-1:0]   rd_shift;
  logic [XLEN-1:0]   rd_ext;

  assign accept = (state_q == IDLE) && (load_i || store_i);
  assign busy_o = (state_q != IDLE);
  assign off    = addr_i[OFF_W-1:0];

  // size_bytes low bits set, one spare bit so a full lane does not wrap
  assign mask_wide = ({{STRB_W{1'b0}}, 1'b1} << size_bytes(size_i))
                   - {{STRB_W{1'b0}}, 1'b1};
  assign lane_mask = mask_wide[STRB_W-1:0] << off;
  assign lane_data = wdata_i << {off, 3'b000};

  assign rd_shift = bus.r_data >> {off_q, 3'b000};

  always_comb begin
    case (size_q)
      SIZE_B:  rd_ext = {{(XLEN-8){sext_q & rd_shift[7]}}, rd_shift[7:0]};
      SIZE_H:  rd_ext = {{(XLEN-16){sext_q & rd_shift[15]}}, rd_shift[15:0]};
      SIZE_W:  rd_ext = {{(XLEN-32){sext_q & rd_shift[31]}}, rd_shift[31:0]};
      default: rd_ext = rd_shift;
    endcase
  end

  // request payload, latched once per operation
  always_ff @(posedge clk) begin
    if (accept) begin
      size_q      <= size_i;
      sext_q      <= sext_i;
      off_q       <= off;
      bus.aw_addr <= addr_i;
      bus.ar_addr <= addr_i;
      bus.w_data  <= lane_data;
      bus.w_strb  <= lane_mask;
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q      <= IDLE;
      bus.aw_valid <= 1'b0;
      bus.ar_valid <= 1'b0;
      bus.b_ready  <= 1'b0;
      bus.r_ready  <= 1'b0;
      done_o       <= 1'b0;
      rdata_o      <= '0;
    end else begin
      done_o <= 1'b0;
      case (state_q)
        IDLE: begin
          if (accept) begin
            bus.aw_valid <= store_i;
            bus.ar_valid <= load_i;
            state_q      <= REQ;
          end
        end
        REQ: begin
          if (bus.aw_valid && bus.aw_ready) begin
            bus.aw_valid <= 1'b0;
            bus.b_ready  <= 1'b1;
            state_q      <= RESP;
          end else if (bus.ar_valid && bus.ar_ready) begin
            bus.ar_valid <= 1'b0;
            bus.r_ready  <= 1'b1;
            state_q      <= RESP;
          end
        end
        RESP: begin
          if (bus.b_valid && bus.b_ready) begin
            bus.b_ready <= 1'b0;
            done_o      <= 1'b1;
            state_q     <= IDLE;
          end else if (bus.r_valid && bus.r_ready) begin
            bus.r_ready <= 1'b0;
            rdata_o     <= rd_ext;  // held until the next load completes
            done_o      <= 1'b1;
            state_q     <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // execute stage must wait for done before the next operation
  a_no_req_busy: assert property (@(posedge clk) disable iff (!arst_n_i)
    busy_o |-> !(load_i || store_i));

  a_one_kind: assert property (@(posedge clk) disable iff (!arst_n_i)
    !(load_i && store_i));

  a_aligned: assert property (@(posedge clk) disable iff (!arst_n_i)
    (load_i || store_i) |-> ((off & OFF_W'(size_bytes(size_i) - 4'd1)) == '0));

endmodule

//--- src/data_ram.sv
// data RAM bus slave: word array, wait-state counter, byte-masked writes
`timescale 1ns/1ps

module data_ram #(
  parameter int DEPTH_WORDS = 256,
  parameter int WAIT_CYCLES = 2
) (
  input logic       clk,
  input logic       arst_n_i,
  dmem_bus_if.slave bus
);

  import lsu_pkg::*;

  localparam int IDX_W = (DEPTH_WORDS > 1) ? $clog2(DEPTH_WORDS) : 1;
  localparam int CNT_W = (WAIT_CYCLES > 0) ? $clog2(WAIT_CYCLES + 1) : 1;

  typedef enum logic [1:0] {
    ST_REQ,
    ST_WRESP,
    ST_RRESP
  } state_e;

  state_e           state_q;
  logic [CNT_W-1:0] wait_q;
  logic             wait_done;
  logic             req_valid;
  logic [XLEN-1:0]  req_addr;
  logic [XLEN-1:0]  word_num;
  logic [IDX_W-1:0] idx;
  logic             wr_fire;
  logic             rd_fire;

  logic [XLEN-1:0] mem [DEPTH_WORDS] = '{default: '0};

  assign req_valid = bus.aw_valid || bus.ar_valid;
  assign req_addr  = bus.aw_valid ? bus.aw_addr : bus.ar_addr;  // write wins
  assign word_num  = req_addr >> OFF_W;
  assign idx       = IDX_W'(word_num % XLEN'(DEPTH_WORDS));
  assign wait_done = (state_q == ST_REQ) && (wait_q == CNT_W'(WAIT_CYCLES));

  assign bus.aw_ready = wait_done && bus.aw_valid;
  assign bus.ar_ready = wait_done && bus.ar_valid && !bus.aw_valid;
  assign wr_fire      = bus.aw_valid && bus.aw_ready;
  assign rd_fire      = bus.ar_valid && bus.ar_ready;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= ST_REQ;
      wait_q      <= '0;
      bus.b_valid <= 1'b0;
      bus.r_valid <= 1'b0;
    end else begin
      case (state_q)
        ST_REQ: begin
          if (wr_fire) begin
            wait_q      <= '0;
            bus.b_valid <= 1'b1;
            state_q     <= ST_WRESP;
          end else if (rd_fire) begin
            wait_q      <= '0;
            bus.r_valid <= 1'b1;
            state_q     <= ST_RRESP;
          end else if (req_valid) begin
            wait_q <= wait_q + CNT_W'(1);  // wait states
          end
        end
        ST_WRESP: begin
          if (bus.b_ready) begin
            bus.b_valid <= 1'b0;
            state_q     <= ST_REQ;
          end
        end
        ST_RRESP: begin
          if (bus.r_ready) begin
            bus.r_valid <= 1'b0;
            state_q     <= ST_REQ;
          end
        end
        default: state_q <= ST_REQ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      for (int i = 0; i < STRB_W; i++) begin
        if (bus.w_strb[i]) begin
          mem[idx][i*8 +: 8] <= bus.w_data[i*8 +: 8];
        end
      end
    end
    if (rd_fire) begin
      bus.r_data <= mem[idx];
    end
  end

  a_one_req: assert property (@(posedge clk) disable iff (!arst_n_i)
    !(bus.aw_valid && bus.ar_valid));

  // responses stay up until the unit takes them
  a_b_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
    (bus.b_valid && !bus.b_ready) |=> bus.b_valid);

  a_r_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
    (bus.r_valid && !bus.r_ready) |=> bus.r_valid);

  a_in_range: assert property (@(posedge clk) disable iff (!arst_n_i)
    req_valid |-> (word_num < XLEN'(DEPTH_WORDS)));

endmodule

//--- src/lsu_top.sv
// lsu top level: load/store unit and data RAM joined by the data memory bus
`timescale 1ns/1ps

module lsu_top #(
  parameter int DEPTH_WORDS = 256,
  parameter int WAIT_CYCLES = 2
) (
  input  logic                     clk,
  input  logic                     arst_n_i,
  input  logic                     load_i,
  input  logic                     store_i,
  input  logic [lsu_pkg::XLEN-1:0] addr_i,
  input  logic [lsu_pkg::XLEN-1:0] wdata_i,
  input  lsu_pkg::mem_size_e       size_i,
  input  logic                     sext_i,
  output logic [lsu_pkg::XLEN-1:0] rdata_o,
  output logic                     done_o,
  output logic                     busy_o
);

  dmem_bus_if bus ();

  load_store_unit u_lsu (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .load_i   (load_i),
    .store_i  (store_i),
    .addr_i   (addr_i),
    .wdata_i  (wdata_i),
    .size_i   (size_i),
    .sext_i   (sext_i),
    .rdata_o  (rdata_o),
    .done_o   (done_o),
    .busy_o   (busy_o),
    .bus      (bus.master)
  );

  data_ram #(
    .DEPTH_WORDS (DEPTH_WORDS),
    .WAIT_CYCLES (WAIT_CYCLES)
  ) u_ram (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .bus      (bus.slave)
  );

endmodule

//--- tests/tb_lsu_top.sv
// testbench for lsu_top: clock, reset, xorshift stimulus, byte model, compare tasks
`timescale 1ns/1ps

module tb_lsu_top;

  import lsu_pkg::*;

  localparam int DEPTH_WORDS = 256;
  localparam int WAIT_CYCLES = 2;
  localparam int TIMEOUT     = 64;   // cycles allowed per operation
  localparam int SOAK_OPS    = 300;
  localparam int SOAK_WORDS  = 8;    // small window so loads hit earlier stores

  logic            clk = 1'b0;
  logic            arst_n_i;
  logic            load_i;
  logic            store_i;
  logic [XLEN-1:0] addr_i;
  logic [XLEN-1:0] wdata_i;
  mem_size_e       size_i;
  logic            sext_i;
  logic [XLEN-1:0] rdata_o;
  logic            done_o;
  logic            busy_o;

  logic [31:0] rng_state = 32'hbba4_0ce0;
  logic [7:0]  model_mem [DEPTH_WORDS*STRB_W];  // byte-wise reference memory

  lsu_top #(
    .DEPTH_WORDS (DEPTH_WORDS),
    .WAIT_CYCLES (WAIT_CYCLES)
  ) DUT (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .load_i   (load_i),
    .store_i  (store_i),
    .addr_i   (addr_i),
    .wdata_i  (wdata_i),
    .size_i   (size_i),
    .sext_i   (sext_i),
    .rdata_o  (rdata_o),
    .done_o   (done_o),
    .busy_o   (busy_o)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // aligned byte address inside the first 'words' RAM words
  function automatic logic [XLEN-1:0] rand_addr(input mem_size_e size, input int words);
    int word;
    int off;
    word = int'(xorshift32() % words);
    off  = int'(xorshift32() % STRB_W) & ~(int'(size_bytes(size)) - 1);
    return XLEN'(word * STRB_W + off);
  endfunction

  function automatic logic [XLEN-1:0] expected_load(input logic [XLEN-1:0] addr,
                                                    input mem_size_e size, input logic sext);
    logic [XLEN-1:0] v;
    int              n;
    v = '0;
    n = int'(size_bytes(size));
    for (int i = 0; i < n; i++) v[i*8 +: 8] = model_mem[int'(addr) + i];
    if (sext && v[n*8-1]) begin
      for (int i = n; i < STRB_W; i++) v[i*8 +: 8] = 8'hff;  // sign fill
    end
    return v;
  endfunction

  task automatic model_store(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] data,
                             input mem_size_e size);
    for (int i = 0; i < int'(size_bytes(size)); i++) begin
      model_mem[int'(addr) + i] = data[i*8 +: 8];
    end
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_data(input string name, input logic [XLEN-1:0] expected,
                            input logic [XLEN-1:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("Mismatch %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      abort_run($sformatf("Mismatch %s expected %b actual %b", name, expected, actual));
    end
  endtask

  // one operation, entered and left on a falling edge
  task automatic run_op(input string name, input logic is_store, input logic [XLEN-1:0] addr,
                        input logic [XLEN-1:0] data, input mem_size_e size, input logic sext);
    int cycles;
    load_i  = !is_store;
    store_i = is_store;
    addr_i  = addr;
    wdata_i = data;
    size_i  = size;
    sext_i  = sext;
    @(negedge clk);
    load_i  = 1'b0;
    store_i = 1'b0;
    check_flag({name, " busy after accept"}, 1'b1, busy_o);
    check_flag({name, " done after accept"}, 1'b0, done_o);
    cycles = 0;
    while (done_o !== 1'b1) begin
      check_flag({name, " busy until done"}, 1'b1, busy_o);
      if (cycles >= TIMEOUT) begin
        abort_run($sformatf("%s: done_o never came within %0d cycles", name, TIMEOUT));
      end
      @(negedge clk);
      cycles++;
    end
    check_flag({name, " busy at done"}, 1'b0, busy_o);  // falls with the done pulse
    if (is_store) model_store(addr, data, size);
    else check_data(name, expected_load(addr, size, sext), rdata_o);
    @(negedge clk);
    check_flag({name, " done pulse width"}, 1'b0, done_o);
  endtask

  initial begin
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] data;
    mem_size_e       size;
    int              n;
    arst_n_i = 1'b0;
    load_i   = 1'b0;
    store_i  = 1'b0;
    addr_i   = '0;
    wdata_i  = '0;
    size_i   = SIZE_D;
    sext_i   = 1'b0;
    for (int i = 0; i < DEPTH_WORDS*STRB_W; i++) model_mem[i] = 8'h00;
    repeat (3) @(negedge clk);
    arst_n_i = 1'b1;

    check_flag("reset busy", 1'b0, busy_o);
    check_flag("reset done", 1'b0, done_o);
    check_data("reset rdata", '0, rdata_o);

    addr = rand_addr(SIZE_D, DEPTH_WORDS);
    data = {xorshift32(), xorshift32()};
    run_op("dword store", 1'b1, addr, data, SIZE_D, 1'b0);
    run_op("dword load", 1'b0, addr, '0, SIZE_D, 1'b0);

    // sub-word stores into a filled lane, read back both ways
    for (int s = 0; s < 3; s++) begin
      size = mem_size_e'(s);
      n    = int'(size_bytes(size));
      for (int off = 0; off < STRB_W; off += n) begin
        addr = XLEN'((xorshift32() % DEPTH_WORDS) * STRB_W);
        run_op("lane fill", 1'b1, addr, {xorshift32(), xorshift32()}, SIZE_D, 1'b0);
        data = {xorshift32(), xorshift32()};
        data[n*8-1] = 1'((off / n) % 2);  // both signs at every size
        addr = addr + XLEN'(off);
        run_op($sformatf("subword store size %0d off %0d", n, off), 1'b1, addr, data, size,
               1'b0);
        run_op($sformatf("zext load size %0d off %0d", n, off), 1'b0, addr, '0, size, 1'b0);
        run_op($sformatf("sext load size %0d off %0d", n, off), 1'b0, addr, '0, size, 1'b1);
        run_op($sformatf("lane check size %0d off %0d", n, off), 1'b0, addr - XLEN'(off), '0,
               SIZE_D, 1'b0);
      end
    end

    for (int i = 0; i < SOAK_OPS; i++) begin
      size = mem_size_e'(xorshift32() % 4);
      addr = rand_addr(size, SOAK_WORDS);
      data = {xorshift32(), xorshift32()};
      n    = int'(xorshift32() % 4);
      run_op($sformatf("soak %0d", i), n[0], addr, data, size, n[1]);
    end

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

//--- sources.f
src/lsu_pkg.sv
src/dmem_bus_if.sv
src/load_store_unit.sv
src/data_ram.sv
src/lsu_top.sv
tests/tb_lsu_top.sv

//--- Makefile
# Verilator build and run for the load/store unit testbench

VERILATOR  ?= verilator
TOP        ?= tb_lsu_top
RTL_TOP    ?= lsu_top
FILELIST   ?= sources.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
RUN_ARGS   ?=

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) $(RUN_ARGS)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
